/* src/mem_burst_pkg.sv */
/*
 * Memory burst mapper package
 * Widths, burst limits, the slave alignment rule and the state
 * encoding of the local memory target
 */

package mem_burst_pkg;

    // Word address; only the low bits reach the memory target
    localparam int ADDR_WIDTH = 16;
    localparam int DATA_WIDTH = 32;
    localparam int BYTE_WIDTH = DATA_WIDTH / 8;

    // Requester bursts run 1 to 16 beats, slave bursts 1 to 4
    localparam int MASTER_BURST_WIDTH = 5;
    localparam int SLAVE_BURST_WIDTH = 3;

    // When set, every slave burst starts on a multiple of its own length
    localparam bit NATURAL_ALIGNMENT = 1'b1;

    // Bit 0 of the user field tags the final slave burst of a requester burst
    localparam int USER_WIDTH = 1;

    localparam int MEM_DEPTH = 256;
    localparam int MEM_ADDR_WIDTH = $clog2(MEM_DEPTH);

    typedef enum logic [1:0] {
        TGT_IDLE,
        TGT_READ,
        TGT_WRITE
    } t_target_state;

endpackage

/* src/mem_rdwr_if.sv */
/*
 * Split read/write memory interface
 * Separate read and write request channels with wait-request flow control,
 * read data return and write responses. Only the burst count width varies
 */

`timescale 1ns/1ps

interface mem_rdwr_if
    import mem_burst_pkg::*;
#(
    parameter int BURST_CNT_WIDTH = MASTER_BURST_WIDTH
)
(
    input logic clk,
    input logic reset_n
);

    // Read request, read flow control and read return
    logic                       rd_read;
    logic [ADDR_WIDTH-1:0]      rd_address;
    logic [BURST_CNT_WIDTH-1:0] rd_burstcount;
    logic                       rd_waitrequest;
    logic [DATA_WIDTH-1:0]      rd_readdata;
    logic                       rd_readdatavalid;

    // Write beats; address and count matter on the first beat only
    logic                       wr_write;
    logic [ADDR_WIDTH-1:0]      wr_address;
    logic [BURST_CNT_WIDTH-1:0] wr_burstcount;
    logic [DATA_WIDTH-1:0]      wr_writedata;
    logic [BYTE_WIDTH-1:0]      wr_byteenable;
    logic [USER_WIDTH-1:0]      wr_user;
    logic                       wr_waitrequest;
    logic                       wr_writeresponsevalid;
    logic [USER_WIDTH-1:0]      wr_writeresponseuser;

    // Seen from a module that faces a master, so it serves requests
    modport to_master (
        input  clk, reset_n,
        input  rd_read, rd_address, rd_burstcount,
        output rd_waitrequest, rd_readdata, rd_readdatavalid,
        input  wr_write, wr_address, wr_burstcount, wr_writedata, wr_byteenable, wr_user,
        output wr_waitrequest, wr_writeresponsevalid, wr_writeresponseuser
    );

    // Seen from a module that faces a slave, so it issues requests
    modport to_slave (
        input  clk, reset_n,
        output rd_read, rd_address, rd_burstcount,
        input  rd_waitrequest, rd_readdata, rd_readdatavalid,
        output wr_write, wr_address, wr_burstcount, wr_writedata, wr_byteenable, wr_user,
        input  wr_waitrequest, wr_writeresponsevalid, wr_writeresponseuser
    );

endinterface

/* src/burst_gearbox.sv */
/*
 * Burst count gearbox
 * Holds one requester burst and hands it out as a run of legal slave
 * bursts, each a power of two of at most four beats
 */

`timescale 1ns/1ps

module burst_gearbox
    import mem_burst_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset_n,

    input  logic                          new_req,
    input  logic [ADDR_WIDTH-1:0]         req_addr,
    input  logic [MASTER_BURST_WIDTH-1:0] req_burstcount,

    input  logic                          accept_req,
    output logic                          req_complete,
    output logic [ADDR_WIDTH-1:0]         slave_addr,
    output logic [SLAVE_BURST_WIDTH-1:0]  slave_burstcount
);

    // Beats of the requester burst not yet handed to the slave
    logic [MASTER_BURST_WIDTH-1:0] remaining;
    logic [ADDR_WIDTH-1:0]         next_addr;

    // Length of the slave burst offered in this cycle
    logic [MASTER_BURST_WIDTH-1:0] slave_len;

    // Walk up the powers of two and keep the largest one that fits.
    // Alignment to a larger size implies alignment to every smaller one
    always_comb
    begin
        slave_len = MASTER_BURST_WIDTH'(1);
        for (int i = 1; i < SLAVE_BURST_WIDTH; i++)
        begin
            if ((MASTER_BURST_WIDTH'(1 << i) <= remaining) &&
                (!NATURAL_ALIGNMENT || ((next_addr & ADDR_WIDTH'((1 << i) - 1)) == '0)))
            begin
                slave_len = MASTER_BURST_WIDTH'(1 << i);
            end
        end
    end

    assign slave_addr = next_addr;
    assign slave_burstcount = SLAVE_BURST_WIDTH'(slave_len);

    // The offered burst covers everything that is left
    assign req_complete = (remaining <= slave_len);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            remaining <= '0;
        end
        else if (new_req)
        begin
            // A new requester burst replaces whatever was finishing
            remaining <= req_burstcount;
            next_addr <= req_addr;
        end
        else if (accept_req)
        begin
            remaining <= remaining - slave_len;
            next_addr <= next_addr + ADDR_WIDTH'(slave_len);
        end
    end

endmodule

/* src/burst_sop_tracker.sv */
/*
 * Write burst start tracker
 * Counts accepted beats and flags when the next beat opens a new burst
 */

`timescale 1ns/1ps

module burst_sop_tracker
    import mem_burst_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          beat_valid,
    input  logic [MASTER_BURST_WIDTH-1:0] burstcount,
    output logic                          sop
);

    // Beats still owed to the burst in flight, counting the next one
    logic [MASTER_BURST_WIDTH-1:0] beats_left;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            sop <= 1'b1;
            beats_left <= '0;
        end
        else if (beat_valid)
        begin
            if (sop)
            begin
                // Count is only meaningful on the first beat
                beats_left <= burstcount - 1'b1;
                sop <= (burstcount == MASTER_BURST_WIDTH'(1));
            end
            else
            begin
                beats_left <= beats_left - 1'b1;
                sop <= (beats_left == MASTER_BURST_WIDTH'(1));
            end
        end
    end

endmodule

/* src/burst_map_ctrl.sv */
/*
 * Burst mapper control
 * Splits requester read and write bursts into legal slave bursts, registers
 * the slave requests and returns one write response per requester burst
 */

`timescale 1ns/1ps

module burst_map_ctrl
    import mem_burst_pkg::*;
(
    mem_rdwr_if.to_master mem_master,
    mem_rdwr_if.to_slave  mem_slave
);

    logic clk;
    logic reset_n;

    assign clk = mem_slave.clk;
    assign reset_n = mem_slave.reset_n;

    logic rd_complete;
    logic rd_next;
    logic rd_accept;

    // A new read can be taken when the slave is free and either nothing is
    // pending or the pending slave burst is the last of its requester burst
    assign rd_next = !mem_slave.rd_waitrequest && (!mem_slave.rd_read || rd_complete);
    assign rd_accept = mem_slave.rd_read && !mem_slave.rd_waitrequest;
    assign mem_master.rd_waitrequest = !rd_next;

    burst_gearbox rd_gearbox_i (
        .clk              (clk),
        .reset_n          (reset_n),
        .new_req          (rd_next && mem_master.rd_read),
        .req_addr         (mem_master.rd_address),
        .req_burstcount   (mem_master.rd_burstcount),
        .accept_req       (rd_accept),
        .req_complete     (rd_complete),
        .slave_addr       (mem_slave.rd_address),
        .slave_burstcount (mem_slave.rd_burstcount)
    );

    // The slave read request stays up until the final slave burst is taken
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            mem_slave.rd_read <= 1'b0;
        end
        else if (rd_next)
        begin
            mem_slave.rd_read <= mem_master.rd_read;
        end
    end

    // Read beats carry no burst framing
    assign mem_master.rd_readdata = mem_slave.rd_readdata;
    assign mem_master.rd_readdatavalid = mem_slave.rd_readdatavalid;

    logic                         wr_complete;
    logic                         m_wr_sop;
    logic                         s_wr_sop;
    logic [ADDR_WIDTH-1:0]        s_wr_address;
    logic [SLAVE_BURST_WIDTH-1:0] s_wr_burstcount;

    // Write beats move one for one, so slave back-pressure goes straight up
    assign mem_master.wr_waitrequest = mem_slave.wr_waitrequest;

    burst_gearbox wr_gearbox_i (
        .clk              (clk),
        .reset_n          (reset_n),
        .new_req          (mem_master.wr_write && !mem_slave.wr_waitrequest && m_wr_sop),
        .req_addr         (mem_master.wr_address),
        .req_burstcount   (mem_master.wr_burstcount),
        .accept_req       (mem_slave.wr_write && !mem_slave.wr_waitrequest && s_wr_sop),
        .req_complete     (wr_complete),
        .slave_addr       (s_wr_address),
        .slave_burstcount (s_wr_burstcount)
    );

    // Address and count go out on slave start beats only
    assign mem_slave.wr_address = s_wr_sop ? s_wr_address : '0;
    assign mem_slave.wr_burstcount = s_wr_sop ? s_wr_burstcount : '0;

    // Tag the first beat of the final slave burst so its response goes up
    assign mem_slave.wr_user = USER_WIDTH'(wr_complete && s_wr_sop);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            mem_slave.wr_write <= 1'b0;
        end
        else if (!mem_slave.wr_waitrequest)
        begin
            mem_slave.wr_write <= mem_master.wr_write;
        end
    end

    // Beat payload follows the same enable as the valid bit
    always_ff @(posedge clk)
    begin
        if (!mem_slave.wr_waitrequest)
        begin
            mem_slave.wr_writedata <= mem_master.wr_writedata;
            mem_slave.wr_byteenable <= mem_master.wr_byteenable;
        end
    end

    // Requester side start of burst, which gates loading of the gearbox
    burst_sop_tracker m_sop_tracker_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .beat_valid (mem_master.wr_write && !mem_master.wr_waitrequest),
        .burstcount (mem_master.wr_burstcount),
        .sop        (m_wr_sop)
    );

    // Slave side start of burst, which advances the gearbox
    burst_sop_tracker s_sop_tracker_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .beat_valid (mem_slave.wr_write && !mem_slave.wr_waitrequest),
        .burstcount (MASTER_BURST_WIDTH'(mem_slave.wr_burstcount)),
        .sop        (s_wr_sop)
    );

    // Untagged responses belong to the extra slave bursts and are dropped
    assign mem_master.wr_writeresponsevalid =
        mem_slave.wr_writeresponsevalid && mem_slave.wr_writeresponseuser[0];
    assign mem_master.wr_writeresponseuser = mem_slave.wr_writeresponseuser;

endmodule

/* src/burst_mem_target.sv */
/*
 * Local memory target
 * A 256-word memory that serves slave bursts. Reads stream one beat per
 * cycle and every write burst returns a single response carrying its tag
 */

`timescale 1ns/1ps

module burst_mem_target
    import mem_burst_pkg::*;
(
    mem_rdwr_if.to_master mem
);

    logic clk;
    logic reset_n;

    assign clk = mem.clk;
    assign reset_n = mem.reset_n;

    logic [DATA_WIDTH-1:0] mem_array [MEM_DEPTH];

    t_target_state state_q;

    logic [MEM_ADDR_WIDTH-1:0]    rd_addr_q;
    logic [SLAVE_BURST_WIDTH-1:0] rd_left_q;
    logic [MEM_ADDR_WIDTH-1:0]    wr_addr_q;
    logic [SLAVE_BURST_WIDTH-1:0] wr_left_q;
    logic [USER_WIDTH-1:0]        wr_user_q;

    logic                      rd_accept;
    logic                      wr_accept;
    logic                      wr_sop;
    logic                      wr_last;
    logic [MEM_ADDR_WIDTH-1:0] wr_idx;

    // Reads are taken only from idle; a pending read blocks a new write
    assign mem.rd_waitrequest = (state_q != TGT_IDLE);
    assign mem.wr_waitrequest = (state_q == TGT_READ) || ((state_q == TGT_IDLE) && mem.rd_read);

    assign rd_accept = mem.rd_read && !mem.rd_waitrequest;
    assign wr_accept = mem.wr_write && !mem.wr_waitrequest;

    // Any write taken from idle opens a burst
    assign wr_sop = (state_q == TGT_IDLE);
    assign wr_idx = wr_sop ? mem.wr_address[MEM_ADDR_WIDTH-1:0] : wr_addr_q;
    assign wr_last = wr_sop ? (mem.wr_burstcount == SLAVE_BURST_WIDTH'(1)) :
                              (wr_left_q == SLAVE_BURST_WIDTH'(1));

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state_q <= TGT_IDLE;
            mem.rd_readdatavalid <= 1'b0;
            mem.wr_writeresponsevalid <= 1'b0;
        end
        else
        begin
            mem.rd_readdatavalid <= 1'b0;
            // One response, the cycle after the last beat of a burst
            mem.wr_writeresponsevalid <= wr_accept && wr_last;

            case (state_q)
                TGT_IDLE:
                begin
                    if (rd_accept)
                    begin
                        // The first beat is already on its way
                        mem.rd_readdatavalid <= 1'b1;
                        if (mem.rd_burstcount != SLAVE_BURST_WIDTH'(1))
                        begin
                            state_q <= TGT_READ;
                        end
                    end
                    else if (wr_accept && !wr_last)
                    begin
                        state_q <= TGT_WRITE;
                    end
                end
                TGT_READ:
                begin
                    mem.rd_readdatavalid <= 1'b1;
                    if (rd_left_q == SLAVE_BURST_WIDTH'(1))
                    begin
                        state_q <= TGT_IDLE;
                    end
                end
                TGT_WRITE:
                begin
                    if (wr_accept && wr_last)
                    begin
                        state_q <= TGT_IDLE;
                    end
                end
                default:
                begin
                    state_q <= TGT_IDLE;
                end
            endcase
        end
    end

    // Read streaming; rd_left_q counts beats after the one being sent
    always_ff @(posedge clk)
    begin
        if (rd_accept)
        begin
            mem.rd_readdata <= mem_array[mem.rd_address[MEM_ADDR_WIDTH-1:0]];
            rd_addr_q <= mem.rd_address[MEM_ADDR_WIDTH-1:0] + 1'b1;
            rd_left_q <= mem.rd_burstcount - 1'b1;
        end
        else if (state_q == TGT_READ)
        begin
            mem.rd_readdata <= mem_array[rd_addr_q];
            rd_addr_q <= rd_addr_q + 1'b1;
            rd_left_q <= rd_left_q - 1'b1;
        end
    end

    // Write beats; only enabled bytes change
    always_ff @(posedge clk)
    begin
        if (wr_accept)
        begin
            for (int b = 0; b < BYTE_WIDTH; b++)
            begin
                if (mem.wr_byteenable[b])
                begin
                    mem_array[wr_idx][8*b +: 8] <= mem.wr_writedata[8*b +: 8];
                end
            end
            wr_addr_q <= wr_idx + 1'b1;
            wr_left_q <= wr_sop ? (mem.wr_burstcount - 1'b1) : (wr_left_q - 1'b1);
            if (wr_sop)
            begin
                wr_user_q <= mem.wr_user;
            end
            // The tag arrives on the first beat and is echoed with the response
            mem.wr_writeresponseuser <= wr_sop ? mem.wr_user : wr_user_q;
        end
    end

endmodule

/* src/mem_burst_top.sv */
/*
 * Memory burst subsystem top level
 * Puts the requester ports onto an interface, maps bursts down to the slave
 * limit and serves them from the local memory target
 */

`timescale 1ns/1ps

module mem_burst_top
    import mem_burst_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset_n,

    input  logic                          rd_read,
    input  logic [ADDR_WIDTH-1:0]         rd_address,
    input  logic [MASTER_BURST_WIDTH-1:0] rd_burstcount,
    output logic                          rd_waitrequest,
    output logic [DATA_WIDTH-1:0]         rd_readdata,
    output logic                          rd_readdatavalid,

    input  logic                          wr_write,
    input  logic [ADDR_WIDTH-1:0]         wr_address,
    input  logic [MASTER_BURST_WIDTH-1:0] wr_burstcount,
    input  logic [DATA_WIDTH-1:0]         wr_writedata,
    input  logic [BYTE_WIDTH-1:0]         wr_byteenable,
    output logic                          wr_waitrequest,
    output logic                          wr_writeresponsevalid
);

    // Requester side at up to 16 beats, slave side at up to 4
    mem_rdwr_if #(.BURST_CNT_WIDTH(MASTER_BURST_WIDTH)) mem_master (.clk(clk), .reset_n(reset_n));
    mem_rdwr_if #(.BURST_CNT_WIDTH(SLAVE_BURST_WIDTH))  mem_slave  (.clk(clk), .reset_n(reset_n));

    assign mem_master.rd_read = rd_read;
    assign mem_master.rd_address = rd_address;
    assign mem_master.rd_burstcount = rd_burstcount;
    assign rd_waitrequest = mem_master.rd_waitrequest;
    assign rd_readdata = mem_master.rd_readdata;
    assign rd_readdatavalid = mem_master.rd_readdatavalid;

    assign mem_master.wr_write = wr_write;
    assign mem_master.wr_address = wr_address;
    assign mem_master.wr_burstcount = wr_burstcount;
    assign mem_master.wr_writedata = wr_writedata;
    assign mem_master.wr_byteenable = wr_byteenable;
    // The requester carries no user bits of its own
    assign mem_master.wr_user = '0;
    assign wr_waitrequest = mem_master.wr_waitrequest;
    assign wr_writeresponsevalid = mem_master.wr_writeresponsevalid;

    burst_map_ctrl map_ctrl_i (
        .mem_master (mem_master),
        .mem_slave  (mem_slave)
    );

    burst_mem_target mem_target_i (
        .mem (mem_slave)
    );

endmodule

/* tests/mem_burst_tb.sv */
/*
 * Memory burst subsystem testbench
 * Directed tests against a reference memory model. Covers split write
 * bursts, byte enables, back-to-back reads and a random mix of bursts
 */

`timescale 1ns/1ps

module mem_burst_tb
    import mem_burst_pkg::*;
();

    localparam int TIMEOUT = 200;

    logic                          clk;
    logic                          reset_n;
    logic                          rd_read;
    logic [ADDR_WIDTH-1:0]         rd_address;
    logic [MASTER_BURST_WIDTH-1:0] rd_burstcount;
    logic                          rd_waitrequest;
    logic [DATA_WIDTH-1:0]         rd_readdata;
    logic                          rd_readdatavalid;
    logic                          wr_write;
    logic [ADDR_WIDTH-1:0]         wr_address;
    logic [MASTER_BURST_WIDTH-1:0] wr_burstcount;
    logic [DATA_WIDTH-1:0]         wr_writedata;
    logic [BYTE_WIDTH-1:0]         wr_byteenable;
    logic                          wr_waitrequest;
    logic                          wr_writeresponsevalid;

    // Reference copy of the target memory, updated as beats are accepted
    logic [DATA_WIDTH-1:0] ref_mem [MEM_DEPTH];
    // Payload of the next write burst
    logic [DATA_WIDTH-1:0] beat_data [16];
    logic [BYTE_WIDTH-1:0] beat_be [16];

    // The monitor only appends; tests keep their own read position
    logic [DATA_WIDTH-1:0] read_q [$];
    logic [DATA_WIDTH-1:0] expect_q [$];
    int read_base = 0;
    int resp_count = 0;
    int resp_base = 0;
    int bursts_written = 0;

    int tests = 0;
    int checks = 0;
    int errors = 0;
    int test_errors = 0;
    string test_name = "setup";
    logic [31:0] rng_state;

    mem_burst_top dut_i (
        .clk                   (clk),
        .reset_n               (reset_n),
        .rd_read               (rd_read),
        .rd_address            (rd_address),
        .rd_burstcount         (rd_burstcount),
        .rd_waitrequest        (rd_waitrequest),
        .rd_readdata           (rd_readdata),
        .rd_readdatavalid      (rd_readdatavalid),
        .wr_write              (wr_write),
        .wr_address            (wr_address),
        .wr_burstcount         (wr_burstcount),
        .wr_writedata          (wr_writedata),
        .wr_byteenable         (wr_byteenable),
        .wr_waitrequest        (wr_waitrequest),
        .wr_writeresponsevalid (wr_writeresponsevalid)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Outputs are registered, so the middle of the cycle is a stable point
    always @(negedge clk)
    begin
        if (reset_n && rd_readdatavalid)
        begin
            read_q.push_back(rd_readdata);
        end
        if (reset_n && wr_writeresponsevalid)
        begin
            resp_count++;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Every bit of the word address shows up in the initial contents
    function automatic logic [31:0] fill_word(input logic [7:0] a);
        return {8'h5a, a, ~a, a ^ 8'h3c};
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            $display("MISMATCH %s %s: expected %h, actual %h",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic abort_run(input string what);
        $display("TIMEOUT in %s: %s did not happen within %0d cycles",
                 test_name, what, TIMEOUT);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors + 1);
        $display("STATUS: FAIL");
        $finish;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = errors;
        tests++;
    endtask

    task automatic end_test();
        if (errors == test_errors)
        begin
            $display("test %s: ok", test_name);
        end
        else
        begin
            $display("test %s: %0d errors", test_name, errors - test_errors);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // A request is taken at the rising edge that ends a cycle with waitrequest low
    task automatic wait_accept(input bit is_write);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while ((is_write ? wr_waitrequest : rd_waitrequest) && cycles < TIMEOUT)
        begin
            cycles++;
            @(negedge clk);
        end
        if (cycles >= TIMEOUT)
        begin
            abort_run(is_write ? "write beat acceptance" : "read request acceptance");
        end
        @(posedge clk);
        #1;
    endtask

    // Sends beat_data and beat_be as one burst and merges enabled bytes into ref_mem
    task automatic write_burst(input logic [7:0] addr, input int len);
        logic [7:0] a;
        wr_write = 1'b1;
        wr_address = ADDR_WIDTH'(addr);
        wr_burstcount = MASTER_BURST_WIDTH'(len);
        for (int i = 0; i < len; i++)
        begin
            wr_writedata = beat_data[i];
            wr_byteenable = beat_be[i];
            wait_accept(1'b1);
            a = addr + 8'(i);
            for (int b = 0; b < BYTE_WIDTH; b++)
            begin
                if (beat_be[i][b])
                begin
                    ref_mem[a][8*b +: 8] = beat_data[i][8*b +: 8];
                end
            end
        end
        wr_write = 1'b0;
        bursts_written++;
    endtask

    // Issues one read burst and queues the words it should return
    task automatic read_request(input logic [7:0] addr, input int len);
        rd_read = 1'b1;
        rd_address = ADDR_WIDTH'(addr);
        rd_burstcount = MASTER_BURST_WIDTH'(len);
        wait_accept(1'b0);
        rd_read = 1'b0;
        for (int i = 0; i < len; i++)
        begin
            expect_q.push_back(ref_mem[addr + 8'(i)]);
        end
    endtask

    // Waits for all queued beats, then a few more cycles so extra beats are caught
    task automatic check_reads();
        int cycles;
        cycles = 0;
        while (read_q.size() < read_base + expect_q.size() && cycles < TIMEOUT)
        begin
            cycles++;
            @(posedge clk);
        end
        if (cycles >= TIMEOUT)
        begin
            abort_run("return of all read beats");
        end
        idle(4);
        check_value("read beat count", 32'(expect_q.size()), 32'(read_q.size() - read_base));
        for (int i = 0; i < expect_q.size(); i++)
        begin
            check_value($sformatf("read beat %0d", i), expect_q[i], read_q[read_base + i]);
        end
        read_base = read_q.size();
        expect_q.delete();
    endtask

    // One response per requester write burst, however it was split
    task automatic check_responses();
        int cycles;
        cycles = 0;
        while (resp_count - resp_base < bursts_written && cycles < TIMEOUT)
        begin
            cycles++;
            @(posedge clk);
        end
        if (cycles >= TIMEOUT)
        begin
            abort_run("arrival of the write responses");
        end
        idle(4);
        check_value("write response count", 32'(bursts_written), 32'(resp_count - resp_base));
        resp_base = resp_count;
        bursts_written = 0;
    endtask

    task automatic test_reset_state();
        start_test("reset state");
        @(negedge clk);
        check_value("rd_readdatavalid", 32'd0, 32'(rd_readdatavalid));
        check_value("wr_writeresponsevalid", 32'd0, 32'(wr_writeresponsevalid));
        check_value("rd_waitrequest", 32'd0, 32'(rd_waitrequest));
        check_value("wr_waitrequest", 32'd0, 32'(wr_waitrequest));
        @(posedge clk);
        #1;
        end_test();
    endtask

    // Gives every word a known value so later reads never see X
    task automatic test_fill();
        start_test("memory fill");
        for (int blk = 0; blk < 16; blk++)
        begin
            for (int i = 0; i < 16; i++)
            begin
                beat_data[i] = fill_word(8'(blk * 16 + i));
                beat_be[i] = 4'hf;
            end
            write_burst(8'(blk * 16), 16);
        end
        check_responses();
        end_test();
    endtask

    task automatic test_single_beat();
        start_test("single beat");
        beat_data[0] = 32'hdeadbeef;
        beat_be[0] = 4'hf;
        write_burst(8'd40, 1);
        check_responses();
        read_request(8'd40, 1);
        check_reads();
        end_test();
    endtask

    // Starting at 3 the mapper needs slave bursts of 1, 4, 4, 4, 2 and 1
    task automatic test_unaligned_split();
        start_test("unaligned 16 beat");
        for (int i = 0; i < 16; i++)
        begin
            beat_data[i] = next_random();
            beat_be[i] = 4'hf;
        end
        write_burst(8'd3, 16);
        check_responses();
        read_request(8'd3, 16);
        check_reads();
        end_test();
    endtask

    task automatic test_byte_enable();
        start_test("byte enables");
        beat_data[0] = 32'h11223344;
        beat_be[0] = 4'b0101;
        write_burst(8'd100, 1);
        beat_be[0] = 4'b0001;
        beat_be[1] = 4'b0010;
        beat_be[2] = 4'b1100;
        beat_be[3] = 4'b0000;
        for (int i = 0; i < 4; i++)
        begin
            beat_data[i] = next_random();
        end
        write_burst(8'd120, 4);
        check_responses();
        read_request(8'd100, 1);
        read_request(8'd120, 4);
        check_reads();
        end_test();
    endtask

    // Requests follow each other as soon as waitrequest allows, 13 beats in all
    task automatic test_back_to_back_reads();
        start_test("back-to-back reads");
        read_request(8'd10, 1);
        read_request(8'd21, 5);
        read_request(8'd50, 7);
        check_reads();
        end_test();
    endtask

    task automatic test_random_mix();
        logic [31:0] r;
        logic [31:0] e;
        int len;
        start_test("random mix");
        for (int n = 0; n < 40; n++)
        begin
            r = next_random();
            len = int'(r[3:0]) + 1;
            if (r[16])
            begin
                for (int i = 0; i < len; i++)
                begin
                    beat_data[i] = next_random();
                    e = next_random();
                    beat_be[i] = e[4] ? 4'hf : e[3:0];
                end
                write_burst(r[15:8], len);
            end
            else
            begin
                read_request(r[15:8], len);
                check_reads();
            end
        end
        check_responses();
        end_test();
    endtask

    initial
    begin
        rng_state = 32'd12793;
        reset_n = 1'b0;
        rd_read = 1'b0;
        rd_address = '0;
        rd_burstcount = '0;
        wr_write = 1'b0;
        wr_address = '0;
        wr_burstcount = '0;
        wr_writedata = '0;
        wr_byteenable = '0;
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;

        test_reset_state();
        test_fill();
        test_single_beat();
        test_unaligned_split();
        test_byte_enable();
        test_back_to_back_reads();
        test_random_mix();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* filelist.f */
src/mem_burst_pkg.sv
src/mem_rdwr_if.sv
src/burst_gearbox.sv
src/burst_sop_tracker.sv
src/burst_map_ctrl.sv
src/burst_mem_target.sv
src/mem_burst_top.sv
tests/mem_burst_tb.sv

/* Makefile */
# Verilator build and run for the memory burst subsystem

VERILATOR  ?= verilator
TOP        ?= mem_burst_tb
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT  ?= STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
